// ==== cpu_macros.svh ====
// global sizing constants for the byte-bus RV32I core
// include wherever a width or reset value is needed
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// fetch starts here after reset
`define CPU_RESET_PC 32'h0000_0000

`define CPU_XLEN 32

`define CPU_NUM_REGS 32

// bytes moved per word on the byte-serial bus
`define CPU_WORD_BYTES 4

`endif

// ==== cpu_pkg.sv ====
// words, register indices, ALU ops and FSM states of the core's instruction side
`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    // anything outside the supported subset decodes to KIND_NOP
    typedef enum logic [2:0] {
        KIND_OP_REG,
        KIND_OP_IMM,
        KIND_LUI,
        KIND_LOAD,
        KIND_STORE,
        KIND_BRANCH_EQ,
        KIND_BRANCH_NE,
        KIND_NOP
    } inst_kind_e;

    typedef enum logic [1:0] {ST_FETCH, ST_EXEC, ST_MEM, ST_WB} core_state_e;

endpackage

// ==== mem_pkg.sv ====
// memory-side types shared by the byte-serial controller and its users

package mem_pkg;

    typedef logic [7:0] byte_t;

    // byte address on the external bus
    typedef logic [31:0] mem_addr_t;

    // lane 0 is the least significant byte
    typedef logic [1:0] lane_t;

    typedef enum logic [1:0] {MS_IDLE, MS_XFER, MS_DONE} mem_state_e;

endpackage

// ==== regfile.sv ====
// integer register file with 2 combinational read ports and 1 write port
// x0 reads as zero and ignores writes
`timescale 1ns/1ps
`include "cpu_macros.svh"

module regfile (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               we_i,
    input  cpu_pkg::reg_addr_t waddr_i,
    input  cpu_pkg::word_t     wdata_i,
    input  cpu_pkg::reg_addr_t raddr1_i,
    input  cpu_pkg::reg_addr_t raddr2_i,
    output cpu_pkg::word_t     rdata1_o,
    output cpu_pkg::word_t     rdata2_o
);
    import cpu_pkg::*;

    word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we_i && (waddr_i != '0))
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== inst_decoder.sv ====
// combinational decode of one RV32I word into kind, ALU op, register fields
// and the sign-extended immediate
`timescale 1ns/1ps

module inst_decoder (
    input  cpu_pkg::word_t     inst_i,
    output cpu_pkg::inst_kind_e kind_o,
    output cpu_pkg::alu_op_e   alu_op_o,
    output cpu_pkg::reg_addr_t rs1_o,
    output cpu_pkg::reg_addr_t rs2_o,
    output cpu_pkg::reg_addr_t rd_o,
    output cpu_pkg::word_t     imm_o
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i_type;
    word_t      imm_s_type;
    word_t      imm_b_type;
    word_t      imm_u_type;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];
    assign rd_o  = inst_i[11:7];

    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
    assign imm_u_type = {inst_i[31:12], 12'h000};

    always_comb
    begin
        kind_o   = KIND_NOP;
        alu_op_o = ALU_ADD;
        imm_o    = imm_i_type;
        case (opcode)
            7'b0110111:
            begin
                kind_o   = KIND_LUI;
                alu_op_o = ALU_PASS_B;
                imm_o    = imm_u_type;
            end
            7'b0010011:
            begin
                kind_o = KIND_OP_IMM;
                case (funct3)
                    3'b000: alu_op_o = ALU_ADD;
                    3'b010: alu_op_o = ALU_SLT;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    3'b001: alu_op_o = ALU_SLL;
                    3'b101: alu_op_o = ALU_SRL;
                    default: kind_o = KIND_NOP;
                endcase
                // shifts need funct7 clear, which also rules out SRAI
                if ((funct3 == 3'b001 || funct3 == 3'b101) && funct7 != 7'b0000000)
                begin
                    kind_o = KIND_NOP;
                end
            end
            7'b0110011:
            begin
                kind_o = KIND_OP_REG;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op_o = ALU_ADD;
                    10'b0100000_000: alu_op_o = ALU_SUB;
                    10'b0000000_010: alu_op_o = ALU_SLT;
                    10'b0000000_100: alu_op_o = ALU_XOR;
                    10'b0000000_110: alu_op_o = ALU_OR;
                    10'b0000000_111: alu_op_o = ALU_AND;
                    default: kind_o = KIND_NOP;
                endcase
            end
            7'b0000011: kind_o = (funct3 == 3'b010) ? KIND_LOAD : KIND_NOP;
            7'b0100011:
            begin
                kind_o = (funct3 == 3'b010) ? KIND_STORE : KIND_NOP;
                imm_o  = imm_s_type;
            end
            7'b1100011:
            begin
                // sub keeps the ALU busy, branches only look at eq
                alu_op_o = ALU_SUB;
                imm_o    = imm_b_type;
                case (funct3)
                    3'b000: kind_o = KIND_BRANCH_EQ;
                    3'b001: kind_o = KIND_BRANCH_NE;
                    default: kind_o = KIND_NOP;
                endcase
            end
            default: kind_o = KIND_NOP;
        endcase
    end

endmodule

// ==== alu.sv ====
// combinational ALU for the kept RV32I subset, with an equality flag for branches
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_e op_i,
    input  cpu_pkg::word_t   a_i,
    input  cpu_pkg::word_t   b_i,
    output cpu_pkg::word_t   res_o,
    output logic             eq_o
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    // only the low five bits count as shift amount
    assign shamt = b_i[4:0];

    always_comb
    begin
        case (op_i)
            ALU_ADD:    res_o = a_i + b_i;
            ALU_SUB:    res_o = a_i - b_i;
            ALU_AND:    res_o = a_i & b_i;
            ALU_OR:     res_o = a_i | b_i;
            ALU_XOR:    res_o = a_i ^ b_i;
            ALU_SLT:    res_o = word_t'($signed(a_i) < $signed(b_i));
            ALU_SLL:    res_o = a_i << shamt;
            ALU_SRL:    res_o = a_i >> shamt;
            ALU_PASS_B: res_o = b_i;
            default:    res_o = '0;
        endcase
    end

    assign eq_o = (a_i == b_i);

endmodule

// ==== core_ctrl.sv ====
// multi-cycle sequencer that holds PC and instruction register
// and runs the req/ack handshake to the memory controller
`timescale 1ns/1ps
`include "cpu_macros.svh"

module core_ctrl (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                rdy_in,
    input  logic                mack_i,
    input  cpu_pkg::word_t      mrdata_i,
    output logic                mreq_o,
    output logic                mwe_o,
    output mem_pkg::mem_addr_t  maddr_o,
    output cpu_pkg::word_t      mwdata_o,
    output cpu_pkg::word_t      inst_o,
    input  cpu_pkg::inst_kind_e kind_i,
    input  cpu_pkg::alu_op_e    alu_op_i,
    input  cpu_pkg::reg_addr_t  rd_i,
    input  cpu_pkg::word_t      imm_i,
    input  cpu_pkg::word_t      rs1_data_i,
    input  cpu_pkg::word_t      rs2_data_i,
    output cpu_pkg::word_t      alu_a_o,
    output cpu_pkg::word_t      alu_b_o,
    input  cpu_pkg::word_t      alu_res_i,
    input  logic                alu_eq_i,
    output logic                rf_we_o,
    output cpu_pkg::reg_addr_t  rf_waddr_o,
    output cpu_pkg::word_t      rf_wdata_o,
    output logic                dbg_wb_valid_o,
    output cpu_pkg::reg_addr_t  dbg_wb_rd_o,
    output cpu_pkg::word_t      dbg_wb_data_o
);
    import cpu_pkg::*;
    import mem_pkg::*;

    core_state_e state;
    word_t       pc;
    word_t       pc_seq;
    word_t       pc_br;
    word_t       wb_data;
    mem_addr_t   eff_addr;
    logic        use_rs2;

    assign pc_seq = pc + `CPU_WORD_BYTES;
    assign pc_br  = pc + imm_i;

    // register-register ops and branches compare two registers
    assign use_rs2 = (kind_i == KIND_OP_REG) || (kind_i == KIND_BRANCH_EQ) ||
                     (kind_i == KIND_BRANCH_NE);
    assign alu_a_o = rs1_data_i;
    assign alu_b_o = use_rs2 ? rs2_data_i : imm_i;

    // low address bits dropped since every access is a word
    assign eff_addr = {alu_res_i[31:2], 2'b00};

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            state  <= ST_FETCH;
            pc     <= `CPU_RESET_PC;
            mreq_o <= 1'b0;
            mwe_o  <= 1'b0;
        end
        else if (rdy_in)
        begin
            case (state)
                ST_FETCH:
                begin
                    if (!mreq_o && !mack_i)
                    begin
                        mreq_o  <= 1'b1;
                        mwe_o   <= 1'b0;
                        maddr_o <= pc;
                    end
                    else if (mreq_o && mack_i)
                    begin
                        mreq_o <= 1'b0;
                        inst_o <= mrdata_i;
                        state  <= ST_EXEC;
                    end
                end
                ST_EXEC:
                begin
                    pc    <= pc_seq;
                    state <= ST_FETCH;
                    case (kind_i)
                        KIND_OP_REG, KIND_OP_IMM, KIND_LUI:
                        begin
                            wb_data <= alu_res_i;
                            state   <= ST_WB;
                        end
                        KIND_LOAD, KIND_STORE:
                        begin
                            maddr_o  <= eff_addr;
                            mwe_o    <= (kind_i == KIND_STORE);
                            mwdata_o <= rs2_data_i;
                            state    <= ST_MEM;
                        end
                        KIND_BRANCH_EQ:
                        begin
                            if (alu_eq_i)
                            begin
                                pc <= pc_br;
                            end
                        end
                        KIND_BRANCH_NE:
                        begin
                            if (!alu_eq_i)
                            begin
                                pc <= pc_br;
                            end
                        end
                        default:
                        begin
                        end
                    endcase
                end
                ST_MEM:
                begin
                    if (!mreq_o && !mack_i)
                    begin
                        mreq_o <= 1'b1;
                    end
                    else if (mreq_o && mack_i)
                    begin
                        mreq_o  <= 1'b0;
                        wb_data <= mrdata_i;
                        state   <= mwe_o ? ST_FETCH : ST_WB;
                    end
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

    // write-back lasts one ready cycle
    assign rf_we_o    = (state == ST_WB) && rdy_in;
    assign rf_waddr_o = rd_i;
    assign rf_wdata_o = wb_data;

    assign dbg_wb_valid_o = rf_we_o && (rd_i != '0);
    assign dbg_wb_rd_o    = rd_i;
    assign dbg_wb_data_o  = wb_data;

endmodule

// ==== byte_mem_ctrl.sv ====
// turns word requests from the core into four byte accesses on the external bus
// read data arrives one ready cycle after its address
`timescale 1ns/1ps

module byte_mem_ctrl (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               rdy_in,
    input  logic               mreq_i,
    input  logic               mwe_i,
    input  mem_pkg::mem_addr_t maddr_i,
    input  cpu_pkg::word_t     mwdata_i,
    output logic               mack_o,
    output cpu_pkg::word_t     mrdata_o,
    input  mem_pkg::byte_t     mem_din_i,
    output mem_pkg::byte_t     mem_dout_o,
    output mem_pkg::mem_addr_t mem_addr_o,
    output logic               mem_wr_o
);
    import cpu_pkg::*;
    import mem_pkg::*;

    mem_state_e state;
    lane_t      lane;        // next lane to put on the bus
    lane_t      cap_lane;    // lane whose byte is in flight
    logic       issue_done;
    logic       rd_pend;
    logic       issuing;
    logic       we_q;
    mem_addr_t  base_q;
    word_t      wdata_q;

    assign issuing    = (state == MS_XFER) && !issue_done;
    assign mem_addr_o = issuing ? base_q + mem_addr_t'(lane) : '0;
    assign mem_wr_o   = issuing && we_q && rdy_in;
    assign mem_dout_o = wdata_q[8*lane +: 8];
    assign mack_o     = (state == MS_DONE);

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            state      <= MS_IDLE;
            lane       <= '0;
            cap_lane   <= '0;
            issue_done <= 1'b0;
            rd_pend    <= 1'b0;
        end
        else if (rdy_in)
        begin
            case (state)
                MS_IDLE:
                begin
                    if (mreq_i && !mack_o)
                    begin
                        state      <= MS_XFER;
                        lane       <= '0;
                        issue_done <= 1'b0;
                        rd_pend    <= 1'b0;
                    end
                end
                MS_XFER:
                begin
                    if (!issue_done)
                    begin
                        lane       <= lane + 2'd1;
                        cap_lane   <= lane;
                        issue_done <= (lane == 2'd3);
                    end
                    rd_pend <= !issue_done && !we_q;
                    // writes end with lane 3, reads one cycle later
                    if (we_q ? (!issue_done && lane == 2'd3) : (rd_pend && cap_lane == 2'd3))
                    begin
                        state <= MS_DONE;
                    end
                end
                MS_DONE:
                begin
                    if (!mreq_i)
                    begin
                        state <= MS_IDLE;
                    end
                end
                default: state <= MS_IDLE;
            endcase
        end
    end

    // request latch and read assembly
    always_ff @(posedge clk_in)
    begin
        if (rdy_in)
        begin
            if (state == MS_IDLE && mreq_i)
            begin
                base_q  <= maddr_i;
                we_q    <= mwe_i;
                wdata_q <= mwdata_i;
            end
            if (state == MS_XFER && rd_pend)
            begin
                mrdata_o[8*cap_lane +: 8] <= mem_din_i;
            end
        end
    end

endmodule

// ==== cpu_top.sv ====
// processor top level that wires core sequencer, decoder, ALU, register file
// and byte bus controller together
`timescale 1ns/1ps

module cpu_top (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               rdy_in,
    input  mem_pkg::byte_t     mem_din_i,
    output mem_pkg::byte_t     mem_dout_o,
    output mem_pkg::mem_addr_t mem_addr_o,
    output logic               mem_wr_o,
    output logic               dbg_wb_valid_o,
    output cpu_pkg::reg_addr_t dbg_wb_rd_o,
    output cpu_pkg::word_t     dbg_wb_data_o
);
    import cpu_pkg::*;
    import mem_pkg::*;

    // core to memory controller handshake
    logic      mreq;
    logic      mwe;
    logic      mack;
    mem_addr_t maddr;
    word_t     mwdata;
    word_t     mrdata;

    word_t      inst;
    inst_kind_e kind;
    alu_op_e    alu_op;
    reg_addr_t  rs1, rs2, rd;
    word_t      imm;
    word_t      rs1_data, rs2_data;
    word_t      alu_a, alu_b, alu_res;
    logic       alu_eq;
    logic       rf_we;
    reg_addr_t  rf_waddr;
    word_t      rf_wdata;

    core_ctrl u_core_ctrl (
        .clk_in, .rst_in, .rdy_in,
        .mack_i(mack), .mrdata_i(mrdata),
        .mreq_o(mreq), .mwe_o(mwe), .maddr_o(maddr), .mwdata_o(mwdata),
        .inst_o(inst),
        .kind_i(kind), .alu_op_i(alu_op), .rd_i(rd), .imm_i(imm),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_res_i(alu_res), .alu_eq_i(alu_eq),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .dbg_wb_valid_o, .dbg_wb_rd_o, .dbg_wb_data_o
    );

    inst_decoder u_inst_decoder (
        .inst_i(inst), .kind_o(kind), .alu_op_o(alu_op),
        .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm)
    );

    alu u_alu (
        .op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .res_o(alu_res), .eq_o(alu_eq)
    );

    regfile u_regfile (
        .clk_in, .rst_in,
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .raddr1_i(rs1), .raddr2_i(rs2), .rdata1_o(rs1_data), .rdata2_o(rs2_data)
    );

    byte_mem_ctrl u_byte_mem_ctrl (
        .clk_in, .rst_in, .rdy_in,
        .mreq_i(mreq), .mwe_i(mwe), .maddr_i(maddr), .mwdata_i(mwdata),
        .mack_o(mack), .mrdata_o(mrdata),
        .mem_din_i, .mem_dout_o, .mem_addr_o, .mem_wr_o
    );

endmodule

// ==== cpu_props.sv ====
// handshake and byte bus assertions bound into byte_mem_ctrl
`timescale 1ns/1ps

module cpu_props (
    input logic               clk_in,
    input logic               rst_in,
    input logic               rdy_in,
    input logic               mreq_i,
    input logic               mack_i,
    input logic               mem_wr_i,
    input mem_pkg::mem_addr_t mem_addr_i
);
    import mem_pkg::*;

    // number of failed assertions so far
    int fails = 0;

    ack_needs_req: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(mack_i) |-> mreq_i)
    else
    begin
        fails++;
        $error("mack rose while mreq was low");
    end

    // ack may only fall once req is gone
    ack_held: assert property (@(posedge clk_in) disable iff (rst_in)
        (mack_i && mreq_i) |=> mack_i)
    else
    begin
        fails++;
        $error("mack fell before mreq was released");
    end

    // byte writes belong to a pending request and never to a not-ready cycle
    no_write_stalled: assert property (@(posedge clk_in) disable iff (rst_in)
        mem_wr_i |-> (rdy_in && mreq_i))
    else
    begin
        fails++;
        $error("byte write strobe outside a ready request cycle");
    end

    addr_frozen: assert property (@(posedge clk_in) disable iff (rst_in)
        !rdy_in |=> $stable(mem_addr_i))
    else
    begin
        fails++;
        $error("bus address moved across a not-ready cycle");
    end

endmodule

bind byte_mem_ctrl cpu_props u_cpu_props (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .rdy_in(rdy_in),
    .mreq_i(mreq_i),
    .mack_i(mack_o),
    .mem_wr_i(mem_wr_o),
    .mem_addr_i(mem_addr_o)
);

// ==== tb_cpu_top.sv ====
// testbench for cpu_top with a random RV32I subset program, a byte RAM with one-cycle
// read delay, random rdy_in stalls and an ISA reference model that predicts every result
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu_top;
    import cpu_pkg::*;
    import mem_pkg::*;

    localparam int NUM_RAND = 60;
    localparam int PROG_LEN = NUM_RAND + 2;
    // 30 cycles per instruction and twice that for rdy_in stalls
    localparam int TIMEOUT_CYCLES = NUM_RAND * 30 * 2;
    localparam int MEM_BYTES = 32'h20000;
    localparam int DATA_BASE = 32'h400;
    localparam mem_addr_t STOP_ADDR = 32'h0003_0004;
    // funct3 of ADD, SLT, XOR, OR, AND
    localparam logic [14:0] ALU_F3 = {3'd7, 3'd6, 3'd4, 3'd2, 3'd0};

    logic      clk_in;
    logic      rst_in;
    logic      rdy_in;
    byte_t     mem_din_i;
    byte_t     mem_dout_o;
    mem_addr_t mem_addr_o;
    logic      mem_wr_o;
    logic      dbg_wb_valid_o;
    reg_addr_t dbg_wb_rd_o;
    word_t     dbg_wb_data_o;

    integer    seed = 32'hcf3c;
    byte_t     ram [MEM_BYTES];
    byte_t     model_mem [MEM_BYTES];
    word_t     prog [PROG_LEN];
    byte_t     rd_byte;
    reg_addr_t exp_rd [$];
    word_t     exp_wb [$];
    mem_addr_t exp_saddr [$];
    byte_t     exp_sbyte [$];
    int        wb_errs = 0;
    int        store_errs = 0;
    int        other_errs = 0;
    int        prop_errs = 0;
    int        cycles = 0;
    logic      stop_seen = 1'b0;
    logic      timed_out = 1'b0;
    logic      first_addr_seen = 1'b0;

    cpu_top u_cpu_top (.*);

    always #50 clk_in = ~clk_in;

    function automatic word_t random_inst(input int idx);
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [11:0] off;
        logic [12:0] boff;
        logic        flip;
        int          k;
        rd   = reg_addr_t'($unsigned($random(seed)) % 8);
        rs1  = reg_addr_t'($unsigned($random(seed)) % 8);
        rs2  = reg_addr_t'($unsigned($random(seed)) % 8);
        imm  = 12'($random(seed));
        f3   = ALU_F3[3 * ($unsigned($random(seed)) % 5) +: 3];
        flip = 1'($random(seed));
        off  = 12'(DATA_BASE + 4 * ($unsigned($random(seed)) % 16));
        // forward branch that never jumps past the stop sequence
        k = 1 + $unsigned($random(seed)) % 4;
        if (idx + k > NUM_RAND)
        begin
            k = NUM_RAND - idx;
        end
        boff = 13'(4 * k);
        case ($unsigned($random(seed)) % 8)
            0: return {20'($random(seed)), rd, 7'b0110111};
            1, 2: return {imm, rs1, f3, rd, 7'b0010011};
            3: return {7'd0, imm[4:0], rs1, flip ? 3'b001 : 3'b101, rd, 7'b0010011};
            4: return {(flip && f3 == 3'd0) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011};
            5: return {off, 5'd0, 3'b010, rd, 7'b0000011};
            6: return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
            default: return {boff[12], boff[10:5], rs2, rs1, 2'b00, flip, boff[4:1],
                             boff[11], 7'b1100011};
        endcase
    endfunction

    task automatic build_memory();
        for (int a = 0; a < MEM_BYTES; a++)
        begin
            ram[a]       = '0;
            model_mem[a] = '0;
        end
        for (int a = DATA_BASE; a < DATA_BASE + 64; a++)
        begin
            ram[a]       = 8'($random(seed));
            model_mem[a] = ram[a];
        end
        for (int i = 0; i < NUM_RAND; i++)
        begin
            prog[i] = random_inst(i);
        end
        // stop sequence loads x31 with the upper stop address and then stores x1 there
        prog[NUM_RAND]     = {STOP_ADDR[31:12], 5'd31, 7'b0110111};
        prog[NUM_RAND + 1] = {STOP_ADDR[11:5], 5'd1, 5'd31, 3'b010, STOP_ADDR[4:0],
                              7'b0100011};
        for (int i = 0; i < PROG_LEN; i++)
        begin
            for (int j = 0; j < 4; j++)
            begin
                ram[`CPU_RESET_PC + 4 * i + j] = prog[i][8 * j +: 8];
            end
        end
    endtask

    function automatic word_t ref_arith(input logic [2:0] f3, input logic sub,
                                        input word_t a, input word_t b);
        case (f3)
            3'd0: return sub ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd4: return a ^ b;
            3'd5: return a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // executes the program in order and queues every expected write-back and byte store
    task automatic run_model();
        word_t regs [32];
        word_t pc;
        word_t pc_next;
        word_t w;
        word_t a;
        word_t b;
        word_t res;
        word_t addr;
        logic  wb;
        logic  done;
        for (int i = 0; i < 32; i++)
        begin
            regs[i] = '0;
        end
        pc   = `CPU_RESET_PC;
        done = 1'b0;
        while (!done && (pc >> 2) < PROG_LEN)
        begin
            w       = prog[pc >> 2];
            a       = regs[w[19:15]];
            b       = regs[w[24:20]];
            wb      = 1'b0;
            res     = '0;
            pc_next = pc + 4;
            case (w[6:0])
                7'b0110111:
                begin
                    res = {w[31:12], 12'h000};
                    wb  = 1'b1;
                end
                7'b0010011:
                begin
                    res = ref_arith(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
                    wb  = 1'b1;
                end
                7'b0110011:
                begin
                    res = ref_arith(w[14:12], w[30], a, b);
                    wb  = 1'b1;
                end
                7'b0000011:
                begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    res  = {model_mem[addr + 3], model_mem[addr + 2],
                            model_mem[addr + 1], model_mem[addr]};
                    wb   = 1'b1;
                end
                7'b0100011:
                begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    for (int j = 0; j < 4; j++)
                    begin
                        exp_saddr.push_back(mem_addr_t'(addr + j));
                        exp_sbyte.push_back(b[8 * j +: 8]);
                        if (addr < MEM_BYTES)
                        begin
                            model_mem[addr + j] = b[8 * j +: 8];
                        end
                    end
                    done = (addr == STOP_ADDR);
                end
                7'b1100011:
                begin
                    if ((w[12] == 1'b0) ? (a == b) : (a != b))
                    begin
                        pc_next = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                default:
                begin
                end
            endcase
            if (wb && w[11:7] != 5'd0)
            begin
                regs[w[11:7]] = res;
                exp_rd.push_back(w[11:7]);
                exp_wb.push_back(res);
            end
            pc = pc_next;
        end
    endtask

    task automatic check_wb(input reg_addr_t rd, input word_t data);
        reg_addr_t want_rd;
        word_t     want_data;
        if (exp_rd.size() == 0)
        begin
            wb_errs++;
            $display("Error at %0t: extra write-back x%0d = %h", $time, rd, data);
        end
        else
        begin
            want_rd   = exp_rd.pop_front();
            want_data = exp_wb.pop_front();
            if (rd !== want_rd || data !== want_data)
            begin
                wb_errs++;
                $display("Error at %0t: write-back x%0d = %h, expected x%0d = %h",
                         $time, rd, data, want_rd, want_data);
            end
        end
    endtask

    task automatic check_store(input mem_addr_t addr, input byte_t data);
        mem_addr_t want_addr;
        byte_t     want_data;
        if (exp_saddr.size() == 0)
        begin
            store_errs++;
            $display("Error at %0t: extra byte write %h to %h", $time, data, addr);
        end
        else
        begin
            want_addr = exp_saddr.pop_front();
            want_data = exp_sbyte.pop_front();
            if (addr !== want_addr || data !== want_data)
            begin
                store_errs++;
                $display("Error at %0t: byte write %h to %h, expected %h to %h",
                         $time, data, addr, want_data, want_addr);
            end
        end
    endtask

    // bus monitor and byte RAM work on the rising edge
    always @(posedge clk_in)
    begin
        if (rst_in)
        begin
            if (mem_wr_o || dbg_wb_valid_o)
            begin
                other_errs++;
                $display("write strobe or write-back pulse active during reset at %0t", $time);
            end
        end
        else
        begin
            cycles++;
            if (cycles >= TIMEOUT_CYCLES)
            begin
                timed_out = 1'b1;
            end
            if (cycles == 1 && (mem_addr_o !== '0 || mem_wr_o || dbg_wb_valid_o))
            begin
                other_errs++;
                $display("bus not idle in the first cycle after reset");
            end
            // first nonzero address is lane 1 of the fetch at the reset PC
            if (!first_addr_seen && mem_addr_o != '0)
            begin
                first_addr_seen = 1'b1;
                if (mem_addr_o != `CPU_RESET_PC + 1)
                begin
                    other_errs++;
                    $display("first fetch did not start at the reset PC");
                end
            end
            if (dbg_wb_valid_o)
            begin
                if (!rdy_in)
                begin
                    other_errs++;
                    $display("write-back pulse in a not-ready cycle at %0t", $time);
                end
                check_wb(dbg_wb_rd_o, dbg_wb_data_o);
            end
            if (mem_wr_o && !rdy_in)
            begin
                other_errs++;
                $display("byte write in a not-ready cycle at %0t", $time);
            end
            if (rdy_in)
            begin
                if (mem_wr_o)
                begin
                    check_store(mem_addr_o, mem_dout_o);
                    if (mem_addr_o < MEM_BYTES)
                    begin
                        ram[mem_addr_o] = mem_dout_o;
                    end
                    if (mem_addr_o == STOP_ADDR + 3)
                    begin
                        stop_seen = 1'b1;
                    end
                end
                rd_byte = ram[mem_addr_o[16:0]];
            end
        end
    end

    // inputs change on the falling edge only
    always @(negedge clk_in)
    begin
        mem_din_i = rd_byte;
        if (cycles > 0)
        begin
            rdy_in = ($unsigned($random(seed)) % 5) != 0;
        end
    end

    initial
    begin
        clk_in    = 1'b0;
        rst_in    = 1'b1;
        rdy_in    = 1'b1;
        mem_din_i = '0;
        rd_byte   = '0;
        build_memory();
        run_model();
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
        wait (stop_seen || timed_out);
        if (timed_out)
        begin
            other_errs++;
            $display("program never reached its stop write within %0d cycles",
                     TIMEOUT_CYCLES);
        end
        else
        begin
            if (exp_rd.size() != 0)
            begin
                other_errs++;
                $display("%0d expected write-backs never appeared", exp_rd.size());
            end
            if (exp_saddr.size() != 0)
            begin
                other_errs++;
                $display("%0d expected byte writes never appeared", exp_saddr.size());
            end
        end
        prop_errs = u_cpu_top.u_byte_mem_ctrl.u_cpu_props.fails;
        $display("errors: %0d write-back, %0d store, %0d assertion, %0d other",
                 wb_errs, store_errs, prop_errs, other_errs);
        if (wb_errs + store_errs + prop_errs + other_errs == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
cpu_pkg.sv
mem_pkg.sv
regfile.sv
inst_decoder.sv
alu.sv
core_ctrl.sv
byte_mem_ctrl.sv
cpu_top.sv
cpu_props.sv
tb_cpu_top.sv

// ==== Bender.yml ====
package:
  name: cpu_byte_bus

export_include_dirs:
  - .

sources:
  - cpu_pkg.sv
  - mem_pkg.sv
  - regfile.sv
  - inst_decoder.sv
  - alu.sv
  - core_ctrl.sv
  - byte_mem_ctrl.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_props.sv
      - tb_cpu_top.sv
